/* test/cb_stim.txt */
# op row col data, row and col in decimal, data in hex
# W writes data, R reads and data is the expected word, I is an idle cycle
W 0 0 11110000
W 9 5 22220005
W 18 3 33330003
R 0 0 11110000
R 9 5 22220005
R 18 3 33330003
W 4 2 44440002
W 23 7 55550007
W 46 10 6666000a
W 79 0 77770000
W 124 127 8888007f
W 127 127 9999007f
I 0 0 00000000
R 4 2 44440002
R 23 7 55550007
R 46 10 6666000a
R 79 0 77770000
R 124 127 8888007f
R 127 127 9999007f
W 0 20 aaaa0014
W 3 20 bbbb0014
R 0 20 bbbb0014
R 3 20 bbbb0014
W 13 1 cccc0001
R 13 1 cccc0001
W 13 1 dddd0001
R 13 1 dddd0001
W 12 0 eeee0015
R 13 1 eeee0015
I 0 0 00000000

/* vlog.f */
common/cb_pkg.sv
cb_agd/cb_agd.sv
verilog/cb_access_ctrl.sv
verilog/cb_ram.sv
verilog/cb_store_top.sv
test/cb_store_tb.sv

/* test/cb_store_tb.sv */
`default_nettype none
`timescale 1ns/10ps

module cb_store_tb;

    import cb_pkg::*;

    // End-to-end read latency and test geometry.
    localparam int READ_LAT    = 6;
    localparam int RST_CYCLES  = 5;
    localparam int FILL_WRITES = 16;
    localparam int MARGIN      = 20;

    logic                clk;
    logic                sys_rst;
    logic                wr_en;
    logic                rd_en;
    logic [ROW_W-1:0]    row;
    logic [COL_W-1:0]    col;
    logic [DATA_W-1:0]   wr_data;
    logic [DATA_W-1:0]   rd_data;
    logic                rd_valid;

    // Reference memory indexed by the row/column address rule.
    logic [DATA_W-1:0]   ref_mem [4096];

    // Expected data and issue cycle of each outstanding read.
    logic [DATA_W-1:0]   exp_data_q [$];
    int                  issue_cyc_q [$];

    // Stimulus loaded from the data file.
    byte                 stim_op [$];
    int                  stim_row [$];
    int                  stim_col [$];
    logic [DATA_W-1:0]   stim_data [$];

    int                  cyc;
    int                  cycle_limit;
    int unsigned         rand_seed;
    logic                expect_now;

    cb_store_top uut (
        .clk      (clk),
        .sys_rst  (sys_rst),
        .wr_en    (wr_en),
        .rd_en    (rd_en),
        .row      (row),
        .col      (col),
        .wr_data  (wr_data),
        .rd_data  (rd_data),
        .rd_valid (rd_valid)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("FAILED %s expected %h actual %h", name, expected, actual));
        end
    endtask

    // Row k*8+i maps to 8k^2 + k, plus 8k + (8 - i) in the upper half.
    function automatic int map_address(input int r, input int c);
        int k;
        int i;
        int a;
        k = r / 8;
        i = r % 8;
        a = 8 * k * k + k;
        if (i >= 4) begin
            a = a + 8 * k + (8 - i);
        end
        return a + c;
    endfunction

    task automatic load_stimulus();
        int                fd;
        int                n;
        byte               op;
        int                r;
        int                c;
        logic [DATA_W-1:0] d;
        reg [1023:0]       line;
        fd = $fopen("test/cb_stim.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open the stimulus file test/cb_stim.txt.");
        end
        while ($fgets(line, fd) != 0) begin
            n = $sscanf(line, "%c %d %d %h", op, r, c, d);
            // Comment and blank lines do not parse to four fields.
            if (n == 4) begin
                if (op != "W" && op != "R" && op != "I") begin
                    abort_run("Stimulus file holds a line with an unknown operation.");
                end
                stim_op.push_back(op);
                stim_row.push_back(r);
                stim_col.push_back(c);
                stim_data.push_back(d);
            end
        end
        $fclose(fd);
    endtask

    // One request per rising edge. The model is updated in issue order.
    task automatic drive_cycle(input byte op, input int r, input int c,
                               input logic [DATA_W-1:0] d);
        int a;
        a = map_address(r, c);
        @(posedge clk);
        wr_en   <= (op == "W");
        rd_en   <= (op == "R");
        row     <= ROW_W'(r);
        col     <= COL_W'(c);
        wr_data <= (op == "W") ? d : '0;
        if (op == "W") begin
            ref_mem[a] = d;
        end else if (op == "R") begin
            exp_data_q.push_back(ref_mem[a]);
            issue_cyc_q.push_back(cyc + 1);
        end
    endtask

    // Free-running cycle count and run limit.
    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cycle_limit > 0 && cyc >= cycle_limit) begin
            abort_run("Timeout, the run did not finish within the cycle limit.");
        end
    end

    // rd_valid must rise exactly READ_LAT cycles after each read and at no other time.
    always @(negedge clk) begin
        if (!sys_rst) begin
            expect_now = (issue_cyc_q.size() > 0) && (cyc - issue_cyc_q[0] == READ_LAT);
            check_val("rd_valid", {31'b0, expect_now}, {31'b0, rd_valid});
            if (expect_now) begin
                check_val("rd_data", exp_data_q[0], rd_data);
                void'(exp_data_q.pop_front());
                void'(issue_cyc_q.pop_front());
            end
        end
    end

    initial begin
        sys_rst     = 1'b1;
        wr_en       = 1'b0;
        rd_en       = 1'b0;
        row         = '0;
        col         = '0;
        wr_data     = '0;
        cyc         = 0;
        cycle_limit = 0;
        rand_seed   = 56776;
        void'($urandom(rand_seed));

        load_stimulus();
        cycle_limit = RST_CYCLES + 2 * FILL_WRITES + stim_op.size() + 1 + MARGIN;

        repeat (RST_CYCLES) @(posedge clk);
        sys_rst <= 1'b0;

        // Fill pass with random words into upper-half rows of every group.
        for (int g = 0; g < FILL_WRITES; g++) begin
            drive_cycle("W", 8 * g + 4 + (g % 4), 2 * g + 1, $urandom());
        end

        // Directed pass from the file. For reads the data column is the expected word.
        for (int n = 0; n < stim_op.size(); n++) begin
            if (stim_op[n] == "R") begin
                check_val("stim_expected", stim_data[n],
                          ref_mem[map_address(stim_row[n], stim_col[n])]);
            end
            drive_cycle(stim_op[n], stim_row[n], stim_col[n], stim_data[n]);
        end

        // Read the fill pass back, one read per cycle.
        for (int g = 0; g < FILL_WRITES; g++) begin
            drive_cycle("R", 8 * g + 4 + (g % 4), 2 * g + 1, '0);
        end
        drive_cycle("I", 0, 0, '0);

        while (exp_data_q.size() != 0) begin
            @(posedge clk);
        end
        // A few quiet cycles so a stray rd_valid is still caught.
        repeat (READ_LAT + 2) @(negedge clk);

        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/cb_store_top.sv */
`default_nettype none
`timescale 1ns/10ps

module cb_store_top (
    input  wire logic                       clk,
    input  wire logic                       sys_rst,
    input  wire logic                       wr_en,
    input  wire logic                       rd_en,
    input  wire logic [cb_pkg::ROW_W-1:0]   row,
    input  wire logic [cb_pkg::COL_W-1:0]   col,
    input  wire logic [cb_pkg::DATA_W-1:0]  wr_data,
    output logic      [cb_pkg::DATA_W-1:0]  rd_data,
    output logic                            rd_valid
);

    import cb_pkg::*;

    logic [CB_AW-1:0]  group_base;
    logic [CB_AW-1:0]  ram_addr;
    logic [DATA_W-1:0] ram_din;
    logic              ram_we;
    logic              ram_re;

    // Row to group base address.
    cb_agd u_agd (
        .clk        (clk),
        .sys_rst    (sys_rst),
        .row        (row),
        .group_base (group_base)
    );

    // Column add and strobe alignment.
    cb_access_ctrl u_ctrl (
        .clk        (clk),
        .sys_rst    (sys_rst),
        .wr_en      (wr_en),
        .rd_en      (rd_en),
        .col        (col),
        .wr_data    (wr_data),
        .group_base (group_base),
        .addr       (ram_addr),
        .we         (ram_we),
        .re         (ram_re),
        .din        (ram_din),
        .rd_valid   (rd_valid)
    );

    // Block storage.
    cb_ram u_ram (
        .clk  (clk),
        .we   (ram_we),
        .re   (ram_re),
        .addr (ram_addr),
        .din  (ram_din),
        .dout (rd_data)
    );

endmodule

`default_nettype wire

/* verilog/cb_ram.sv */
`default_nettype none
`timescale 1ns/10ps

module cb_ram (
    input  wire logic                       clk,
    input  wire logic                       we,
    input  wire logic                       re,
    input  wire logic [cb_pkg::CB_AW-1:0]   addr,
    input  wire logic [cb_pkg::DATA_W-1:0]  din,
    output logic      [cb_pkg::DATA_W-1:0]  dout
);

    import cb_pkg::*;

    localparam int DEPTH = 2 ** CB_AW;

    logic [DATA_W-1:0] mem [DEPTH];

    // Write port.
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= din;
        end
    end

    // Registered read, output holds between reads.
    always_ff @(posedge clk) begin
        if (re) begin
            dout <= mem[addr];
        end
    end

endmodule

`default_nettype wire

/* verilog/cb_access_ctrl.sv */
`default_nettype none
`timescale 1ns/10ps

module cb_access_ctrl (
    input  wire logic                       clk,
    input  wire logic                       sys_rst,
    input  wire logic                       wr_en,
    input  wire logic                       rd_en,
    input  wire logic [cb_pkg::COL_W-1:0]   col,
    input  wire logic [cb_pkg::DATA_W-1:0]  wr_data,
    input  wire logic [cb_pkg::CB_AW-1:0]   group_base,
    output logic      [cb_pkg::CB_AW-1:0]   addr,
    output logic                            we,
    output logic                            re,
    output logic      [cb_pkg::DATA_W-1:0]  din,
    output logic                            rd_valid
);

    import cb_pkg::*;

    // Delay lines that match the address generator latency.
    logic [COL_W-1:0]   col_sr  [AGD_LAT];
    logic [DATA_W-1:0]  data_sr [AGD_LAT];
    logic [AGD_LAT-1:0] wr_sr;
    logic [AGD_LAT-1:0] rd_sr;

    // Tracks reads through the RAM output register.
    logic [RD_LAT-1:0]  re_sr;

    // Request side delay line.
    always_ff @(posedge clk) begin
        if (sys_rst) begin
            for (int i = 0; i < AGD_LAT; i++) begin
                col_sr[i]  <= '0;
                data_sr[i] <= '0;
            end
            wr_sr <= '0;
            rd_sr <= '0;
        end else begin
            col_sr[0]  <= col;
            data_sr[0] <= wr_data;
            wr_sr[0]   <= wr_en;
            rd_sr[0]   <= rd_en;
            for (int i = 1; i < AGD_LAT; i++) begin
                col_sr[i]  <= col_sr[i-1];
                data_sr[i] <= data_sr[i-1];
                wr_sr[i]   <= wr_sr[i-1];
                rd_sr[i]   <= rd_sr[i-1];
            end
        end
    end

    // Final address and strobes, now lined up with group_base.
    always_ff @(posedge clk) begin
        if (sys_rst) begin
            addr <= '0;
            we   <= 1'b0;
            re   <= 1'b0;
            din  <= '0;
        end else begin
            addr <= group_base + CB_AW'(col_sr[AGD_LAT-1]);
            we   <= wr_sr[AGD_LAT-1];
            re   <= rd_sr[AGD_LAT-1];
            din  <= data_sr[AGD_LAT-1];
        end
    end

    // Valid follows re by the RAM read latency.
    always_ff @(posedge clk) begin
        if (sys_rst) begin
            re_sr <= '0;
        end else begin
            re_sr[0] <= re;
            for (int i = 1; i < RD_LAT; i++) begin
                re_sr[i] <= re_sr[i-1];
            end
        end
    end

    assign rd_valid = re_sr[RD_LAT-1];

endmodule

`default_nettype wire

/* cb_agd/cb_agd.sv */
`default_nettype none
`timescale 1ns/10ps

module cb_agd (
    input  wire logic                      clk,
    input  wire logic                      sys_rst,
    input  wire logic [cb_pkg::ROW_W-1:0]  row,
    output logic      [cb_pkg::CB_AW-1:0]  group_base
);

    import cb_pkg::*;

    // Stage 1: group number and index inside the group.
    logic [GRP_W-1:0] k;
    logic [2:0]       idx;

    // Stage 2: k squared, offset seed, delayed k and index.
    logic [CB_AW-1:0] k_sq;
    logic [CB_AW-1:0] off_t;
    logic [GRP_W-1:0] k_r1;
    logic [2:0]       idx_r1;

    // Stage 3: group base and index-dependent offset.
    logic [CB_AW-1:0] base;
    logic [CB_AW-1:0] offset;

    // Zero-extended copies so the products are formed at full address width.
    logic [CB_AW-1:0] k_w;
    logic [CB_AW-1:0] k_r1_w;

    assign k_w    = CB_AW'(k);
    assign k_r1_w = CB_AW'(k_r1);

    // Stage 1.
    always_ff @(posedge clk) begin
        if (sys_rst) begin
            k   <= '0;
            idx <= '0;
        end else begin
            k   <= row[ROW_W-1:3];
            idx <= row[2:0];
        end
    end

    // Stage 2. Only the upper half of a group gets the 8*k term.
    always_ff @(posedge clk) begin
        if (sys_rst) begin
            k_sq   <= '0;
            off_t  <= '0;
            k_r1   <= '0;
            idx_r1 <= '0;
        end else begin
            k_sq   <= k_w * k_w;
            off_t  <= idx[2] ? (k_w << 3) : '0;
            k_r1   <= k;
            idx_r1 <= idx;
        end
    end

    // Stage 3, base of the group is 8*k*k + k.
    always_ff @(posedge clk) begin
        if (sys_rst) begin
            base <= '0;
        end else begin
            base <= (k_sq << 3) + k_r1_w;
        end
    end

    // Stage 3, offset for rows 4 to 7 is 8*k + (8 - i).
    // Rows 0 to 3 all share the group base.
    always_ff @(posedge clk) begin
        if (sys_rst) begin
            offset <= '0;
        end else begin
            case (idx_r1)
                3'd4:    offset <= off_t + CB_AW'(4);
                3'd5:    offset <= off_t + CB_AW'(3);
                3'd6:    offset <= off_t + CB_AW'(2);
                3'd7:    offset <= off_t + CB_AW'(1);
                default: offset <= '0;
            endcase
        end
    end

    // Stage 4.
    always_ff @(posedge clk) begin
        if (sys_rst) begin
            group_base <= '0;
        end else begin
            group_base <= base + offset;
        end
    end

endmodule

`default_nettype wire

/* common/cb_pkg.sv */
`default_nettype none

package cb_pkg;

    // Row and column indices into the information block.
    localparam int ROW_W = 7;
    localparam int COL_W = 7;

    // Landmark rows come in groups of eight.
    localparam int GRP_W = ROW_W - 3;

    // Storage geometry, 4096 words of 32 bits.
    localparam int CB_AW  = 12;
    localparam int DATA_W = 32;

    // Cycles from row input to group base.
    localparam int AGD_LAT = 4;

    // Cycles from group base to final address and aligned strobes.
    localparam int CTRL_LAT = 1;

    // RAM read latency.
    localparam int RD_LAT = 1;

    // Read request to rd_valid, end to end.
    localparam int TOTAL_LAT = AGD_LAT + CTRL_LAT + RD_LAT;

endpackage

`default_nettype wire
